// ==== verilog/id_pkg.sv ====
`default_nettype none

package id_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int ALU_OP_W   = 12;

    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

    // one-hot alu_op bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // SPECIAL function codes
    localparam logic [5:0] FUNC_SLL  = 6'h00;
    localparam logic [5:0] FUNC_SRL  = 6'h02;
    localparam logic [5:0] FUNC_SRA  = 6'h03;
    localparam logic [5:0] FUNC_JR   = 6'h08;
    localparam logic [5:0] FUNC_ADDU = 6'h21;
    localparam logic [5:0] FUNC_SUBU = 6'h23;
    localparam logic [5:0] FUNC_AND  = 6'h24;
    localparam logic [5:0] FUNC_OR   = 6'h25;
    localparam logic [5:0] FUNC_XOR  = 6'h26;
    localparam logic [5:0] FUNC_NOR  = 6'h27;
    localparam logic [5:0] FUNC_SLT  = 6'h2a;
    localparam logic [5:0] FUNC_SLTU = 6'h2b;

    // REGIMM codes carried in the rt field
    localparam logic [4:0] RT_BLTZ = 5'h00;
    localparam logic [4:0] RT_BGEZ = 5'h01;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] inst;
    } fetch_bus_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [DATA_W-1:0]     wdata;
    } wb_bus_t;

    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [DATA_W-1:0]     data;
        logic                  is_load;
    } fwd_src_t;

    typedef struct packed {
        logic [ALU_OP_W-1:0]   alu_op;
        logic                  src1_is_sa;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  src2_is_zext;
        logic                  src2_is_8;
        logic                  mem_read;
        logic                  mem_we;
        logic                  gr_we;
        logic [REG_ADDR_W-1:0] dest;
        logic                  reserved_inst;
    } ctrl_t;

    typedef struct packed {
        ctrl_t             ctrl;
        logic [15:0]       imm;
        logic [DATA_W-1:0] rs_value;
        logic [DATA_W-1:0] rt_value;
        logic [DATA_W-1:0] pc;
    } ds_to_es_t;

    typedef struct packed {
        logic              taken;
        logic [DATA_W-1:0] target;
    } br_bus_t;

    // j and jal share one kind
    typedef struct packed {
        logic beq;
        logic bne;
        logic bgez;
        logic bgtz;
        logic blez;
        logic bltz;
        logic jmp;
        logic jr;
    } br_kind_t;

endpackage

`default_nettype wire

// ==== verilog/regfile.sv ====
`default_nettype none

module regfile
    import id_pkg::*;
(
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    input  wb_bus_t               wb,
    output logic [DATA_W-1:0]     rdata1,
    output logic [DATA_W-1:0]     rdata2
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    // register 0 is never written
    always_ff @(posedge clk) begin
        if (wb.we && wb.waddr != '0) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== verilog/operand_bypass.sv ====
`default_nettype none

module operand_bypass
    import id_pkg::*;
(
    input  logic [REG_ADDR_W-1:0] raddr,
    input  logic [DATA_W-1:0]     rf_data,
    input  fwd_src_t              es_fwd,
    input  fwd_src_t              ms_fwd,
    input  wb_bus_t               wb,
    output logic [DATA_W-1:0]     value,
    output logic                  hazard
);

    logic nonzero;
    logic es_hit;
    logic ms_hit;
    logic wb_hit;

    assign nonzero = (raddr != '0);

    assign es_hit = nonzero & es_fwd.valid & es_fwd.we & (es_fwd.waddr == raddr);
    assign ms_hit = nonzero & ms_fwd.valid & ms_fwd.we & (ms_fwd.waddr == raddr);
    assign wb_hit = nonzero & wb.we & (wb.waddr == raddr);

    // youngest producer wins
    assign value = es_hit ? es_fwd.data :
                   ms_hit ? ms_fwd.data :
                   wb_hit ? wb.wdata : rf_data;

    // load data not ready until memory stage
    assign hazard = es_hit & es_fwd.is_load;

endmodule

`default_nettype wire

// ==== verilog/id_decoder.sv ====
`default_nettype none

module id_decoder
    import id_pkg::*;
(
    input  logic [DATA_W-1:0]     inst,
    output ctrl_t                 ctrl,
    output logic [15:0]           imm,
    output logic [REG_ADDR_W-1:0] rs_addr,
    output logic [REG_ADDR_W-1:0] rt_addr,
    output br_kind_t              br_kind
);

    logic [5:0]            op;
    logic [5:0]            func;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] sa;
    logic                  special;
    logic                  inst_addu;
    logic                  inst_subu;
    logic                  inst_slt;
    logic                  inst_sltu;
    logic                  inst_and;
    logic                  inst_or;
    logic                  inst_xor;
    logic                  inst_nor;
    logic                  inst_sll;
    logic                  inst_srl;
    logic                  inst_sra;
    logic                  inst_addiu;
    logic                  inst_lui;
    logic                  inst_lw;
    logic                  inst_sw;
    logic                  inst_j;
    logic                  inst_jal;
    logic                  inst_jr;
    logic                  dst_is_rd;
    logic                  dst_is_rt;
    logic                  known;

    assign op   = inst[31:26];
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = inst[5:0];

    assign special = (op == OP_SPECIAL);

    // three-register ops need a zero sa field
    assign inst_addu  = special & (func == FUNC_ADDU) & (sa == '0);
    assign inst_subu  = special & (func == FUNC_SUBU) & (sa == '0);
    assign inst_slt   = special & (func == FUNC_SLT)  & (sa == '0);
    assign inst_sltu  = special & (func == FUNC_SLTU) & (sa == '0);
    assign inst_and   = special & (func == FUNC_AND)  & (sa == '0);
    assign inst_or    = special & (func == FUNC_OR)   & (sa == '0);
    assign inst_xor   = special & (func == FUNC_XOR)  & (sa == '0);
    assign inst_nor   = special & (func == FUNC_NOR)  & (sa == '0);
    // shifts by sa leave rs zero
    assign inst_sll   = special & (func == FUNC_SLL)  & (rs == '0);
    assign inst_srl   = special & (func == FUNC_SRL)  & (rs == '0);
    assign inst_sra   = special & (func == FUNC_SRA)  & (rs == '0);
    assign inst_jr    = special & (func == FUNC_JR) & (rt == '0) & (rd == '0) & (sa == '0);
    assign inst_addiu = (op == OP_ADDIU);
    assign inst_lui   = (op == OP_LUI) & (rs == '0);
    assign inst_lw    = (op == OP_LW);
    assign inst_sw    = (op == OP_SW);
    assign inst_j     = (op == OP_J);
    assign inst_jal   = (op == OP_JAL);

    assign br_kind.beq  = (op == OP_BEQ);
    assign br_kind.bne  = (op == OP_BNE);
    assign br_kind.bgez = (op == OP_REGIMM) & (rt == RT_BGEZ);
    assign br_kind.bltz = (op == OP_REGIMM) & (rt == RT_BLTZ);
    assign br_kind.bgtz = (op == OP_BGTZ) & (rt == '0);
    assign br_kind.blez = (op == OP_BLEZ) & (rt == '0);
    assign br_kind.jmp  = inst_j | inst_jal;
    assign br_kind.jr   = inst_jr;

    assign dst_is_rd = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or
                     | inst_xor | inst_nor | inst_sll | inst_srl | inst_sra;
    assign dst_is_rt = inst_addiu | inst_lui | inst_lw;

    assign known = dst_is_rd | dst_is_rt | inst_sw | inst_j | inst_jal | inst_jr
                 | br_kind.beq | br_kind.bne | br_kind.bgez | br_kind.bltz
                 | br_kind.bgtz | br_kind.blez;

    always_comb begin
        ctrl = '0;
        ctrl.alu_op[ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal;
        ctrl.alu_op[ALU_SUB]  = inst_subu;
        ctrl.alu_op[ALU_SLT]  = inst_slt;
        ctrl.alu_op[ALU_SLTU] = inst_sltu;
        ctrl.alu_op[ALU_AND]  = inst_and;
        ctrl.alu_op[ALU_NOR]  = inst_nor;
        ctrl.alu_op[ALU_OR]   = inst_or;
        ctrl.alu_op[ALU_XOR]  = inst_xor;
        ctrl.alu_op[ALU_SLL]  = inst_sll;
        ctrl.alu_op[ALU_SRL]  = inst_srl;
        ctrl.alu_op[ALU_SRA]  = inst_sra;
        ctrl.alu_op[ALU_LUI]  = inst_lui;
        ctrl.src1_is_sa    = inst_sll | inst_srl | inst_sra;
        // jal links pc + 8
        ctrl.src1_is_pc    = inst_jal;
        ctrl.src2_is_8     = inst_jal;
        ctrl.src2_is_imm   = inst_addiu | inst_lui | inst_lw | inst_sw;
        ctrl.src2_is_zext  = 1'b0;
        ctrl.mem_read      = inst_lw;
        ctrl.mem_we        = inst_sw;
        ctrl.gr_we         = dst_is_rd | dst_is_rt | inst_jal;
        ctrl.dest          = inst_jal  ? LINK_REG :
                             dst_is_rt ? rt :
                             dst_is_rd ? rd : '0;
        ctrl.reserved_inst = ~known;
    end

    assign imm     = inst[15:0];
    assign rs_addr = rs;
    assign rt_addr = rt;

endmodule

`default_nettype wire

// ==== verilog/branch_unit.sv ====
`default_nettype none

module branch_unit
    import id_pkg::*;
(
    input  br_kind_t          br_kind,
    input  logic [DATA_W-1:0] pc,
    input  logic [15:0]       imm,
    input  logic [25:0]       jidx,
    input  logic [DATA_W-1:0] rs_value,
    input  logic [DATA_W-1:0] rt_value,
    input  logic              ds_valid,
    input  logic              ready_go,
    output br_bus_t           br_bus
);

    logic              rs_eq_rt;
    logic              rs_lt_zero;
    logic              rs_le_zero;
    logic              cond_br;
    logic              cond_taken;
    logic [DATA_W-1:0] pc_plus4;
    logic [DATA_W-1:0] br_offset;

    assign rs_eq_rt   = (rs_value == rt_value);
    assign rs_lt_zero = rs_value[DATA_W-1];
    assign rs_le_zero = rs_lt_zero | (rs_value == '0);

    assign cond_br = br_kind.beq | br_kind.bne | br_kind.bgez | br_kind.bltz
                   | br_kind.blez | br_kind.bgtz;

    assign cond_taken = (br_kind.beq  &  rs_eq_rt)
                      | (br_kind.bne  & ~rs_eq_rt)
                      | (br_kind.bgez & ~rs_lt_zero)
                      | (br_kind.bltz &  rs_lt_zero)
                      | (br_kind.blez &  rs_le_zero)
                      | (br_kind.bgtz & ~rs_le_zero);

    // no redirect from an empty or stalled stage
    assign br_bus.taken = (cond_taken | br_kind.jmp | br_kind.jr) & ds_valid & ready_go;

    assign pc_plus4  = pc + 32'd4;
    assign br_offset = {{14{imm[15]}}, imm, 2'b00};

    assign br_bus.target = cond_br    ? pc_plus4 + br_offset :
                           br_kind.jr ? rs_value :
                           {pc_plus4[31:28], jidx, 2'b00};

endmodule

`default_nettype wire

// ==== verilog/id_pipe_reg.sv ====
`default_nettype none

module id_pipe_reg
    import id_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       fs_valid,
    input  fetch_bus_t fs_bus,
    input  logic       es_allowin,
    input  logic       rs_hazard,
    input  logic       rt_hazard,
    output logic       ds_valid,
    output logic       ds_allowin,
    output logic       ds_to_es_valid,
    output fetch_bus_t ds_bus
);

    logic ds_ready_go;

    // a load in execute feeding either operand holds the stage
    assign ds_ready_go    = ~(rs_hazard | rt_hazard);
    assign ds_to_es_valid = ds_valid & ds_ready_go;
    assign ds_allowin     = ~ds_valid | (ds_ready_go & es_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_bus <= fs_bus;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/id_stage.sv ====
`default_nettype none

module id_stage
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      fs_valid,
    input  fetch_bus_t fs_bus,
    input  logic      es_allowin,
    input  fwd_src_t  es_fwd,
    input  fwd_src_t  ms_fwd,
    input  wb_bus_t   wb_bus,
    output logic      ds_allowin,
    output logic      ds_to_es_valid,
    output ds_to_es_t ds_to_es_bus,
    output br_bus_t   br_bus
);

    logic                  ds_valid;
    fetch_bus_t            ds_bus;
    ctrl_t                 ctrl;
    logic [15:0]           imm;
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    br_kind_t              br_kind;
    logic [DATA_W-1:0]     rf_rdata1;
    logic [DATA_W-1:0]     rf_rdata2;
    logic [DATA_W-1:0]     rs_value;
    logic [DATA_W-1:0]     rt_value;
    logic                  rs_hazard;
    logic                  rt_hazard;

    id_pipe_reg u_pipe_reg (
        .clk            (clk),
        .reset          (reset),
        .fs_valid       (fs_valid),
        .fs_bus         (fs_bus),
        .es_allowin     (es_allowin),
        .rs_hazard      (rs_hazard),
        .rt_hazard      (rt_hazard),
        .ds_valid       (ds_valid),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_bus         (ds_bus)
    );

    id_decoder u_decoder (
        .inst    (ds_bus.inst),
        .ctrl    (ctrl),
        .imm     (imm),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .br_kind (br_kind)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs_addr),
        .raddr2 (rt_addr),
        .wb     (wb_bus),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    operand_bypass rs_bypass (
        .raddr   (rs_addr),
        .rf_data (rf_rdata1),
        .es_fwd  (es_fwd),
        .ms_fwd  (ms_fwd),
        .wb      (wb_bus),
        .value   (rs_value),
        .hazard  (rs_hazard)
    );

    operand_bypass rt_bypass (
        .raddr   (rt_addr),
        .rf_data (rf_rdata2),
        .es_fwd  (es_fwd),
        .ms_fwd  (ms_fwd),
        .wb      (wb_bus),
        .value   (rt_value),
        .hazard  (rt_hazard)
    );

    branch_unit u_branch (
        .br_kind  (br_kind),
        .pc       (ds_bus.pc),
        .imm      (imm),
        .jidx     (ds_bus.inst[25:0]),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .ds_valid (ds_valid),
        .ready_go (~(rs_hazard | rt_hazard)),
        .br_bus   (br_bus)
    );

    assign ds_to_es_bus.ctrl     = ctrl;
    assign ds_to_es_bus.imm      = imm;
    assign ds_to_es_bus.rs_value = rs_value;
    assign ds_to_es_bus.rt_value = rt_value;
    assign ds_to_es_bus.pc       = ds_bus.pc;

endmodule

`default_nettype wire

// ==== testbench/id_stage_props.sv ====
`default_nettype none

module id_stage_props
    import id_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      ds_valid,
    input logic      ds_allowin,
    input logic      ds_to_es_valid,
    input logic      es_allowin,
    input ds_to_es_t ds_to_es_bus,
    input fwd_src_t  es_fwd,
    input fwd_src_t  ms_fwd,
    input wb_bus_t   wb_bus
);
    timeunit 1ns;
    timeprecision 1ps;

    valid_needs_held: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> ds_valid)
        else $error("ds_to_es_valid high with an empty stage");

    // payload may only move when a forwarding source moves
    bus_held: assert property (@(posedge clk) disable iff (reset)
        (ds_to_es_valid && !es_allowin)
        ##1 ($stable(es_fwd) && $stable(ms_fwd) && $stable(wb_bus))
        |-> $stable(ds_to_es_bus))
        else $error("ds_to_es_bus changed while execute was not ready");

    allowin_after_reset: assert property (@(posedge clk) $fell(reset) |-> ds_allowin)
        else $error("ds_allowin low right after reset");

endmodule

bind id_stage id_stage_props props0 (
    .clk            (clk),
    .reset          (reset),
    .ds_valid       (ds_valid),
    .ds_allowin     (ds_allowin),
    .ds_to_es_valid (ds_to_es_valid),
    .es_allowin     (es_allowin),
    .ds_to_es_bus   (ds_to_es_bus),
    .es_fwd         (es_fwd),
    .ms_fwd         (ms_fwd),
    .wb_bus         (wb_bus)
);

`default_nettype wire

// ==== testbench/tb_id_stage.sv ====
`default_nettype none

module tb_id_stage
    import id_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum int {
        K_ADDU, K_SUBU, K_SLT, K_SLTU, K_AND, K_OR, K_XOR, K_NOR, K_SLL, K_SRL, K_SRA,
        K_ADDIU, K_LUI, K_LW, K_SW, K_BEQ, K_BNE, K_BGEZ, K_BGTZ, K_BLEZ, K_BLTZ,
        K_J, K_JAL, K_JR, K_RSV
    } kind_e;

    localparam int NUM_XFERS  = 400;
    localparam int MAX_CYCLES = 6000;

    logic       clk;
    logic       reset;
    logic       fs_valid;
    fetch_bus_t fs_bus;
    logic       es_allowin;
    fwd_src_t   es_fwd;
    fwd_src_t   ms_fwd;
    wb_bus_t    wb_bus;
    logic       ds_allowin;
    logic       ds_to_es_valid;
    ds_to_es_t  ds_to_es_bus;
    br_bus_t    br_bus;

    logic [31:0] lfsr = 32'd67823;
    logic [31:0] reg_model [NUM_REGS];
    logic [31:0] q_pc[$];
    logic [31:0] q_inst[$];
    int          q_kind[$];
    logic [31:0] next_pc;
    logic [31:0] last_pc;
    int          cur_kind;
    int          xfers;
    int          cycles;
    int          checks;
    int          errors;
    int          timeouts;

    id_stage dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rnd(int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] make_inst(int kind);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [15:0] imm;
        rs  = 5'(rnd(3));
        rt  = 5'(rnd(3));
        rd  = 5'(rnd(3));
        sa  = 5'(rnd(5));
        imm = 16'(rnd(16));
        case (kind)
            K_ADDU:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FUNC_ADDU};
            K_SUBU:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FUNC_SUBU};
            K_SLT:   return {OP_SPECIAL, rs, rt, rd, 5'd0, FUNC_SLT};
            K_SLTU:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FUNC_SLTU};
            K_AND:   return {OP_SPECIAL, rs, rt, rd, 5'd0, FUNC_AND};
            K_OR:    return {OP_SPECIAL, rs, rt, rd, 5'd0, FUNC_OR};
            K_XOR:   return {OP_SPECIAL, rs, rt, rd, 5'd0, FUNC_XOR};
            K_NOR:   return {OP_SPECIAL, rs, rt, rd, 5'd0, FUNC_NOR};
            K_SLL:   return {OP_SPECIAL, 5'd0, rt, rd, sa, FUNC_SLL};
            K_SRL:   return {OP_SPECIAL, 5'd0, rt, rd, sa, FUNC_SRL};
            K_SRA:   return {OP_SPECIAL, 5'd0, rt, rd, sa, FUNC_SRA};
            K_ADDIU: return {OP_ADDIU, rs, rt, imm};
            K_LUI:   return {OP_LUI, 5'd0, rt, imm};
            K_LW:    return {OP_LW, rs, rt, imm};
            K_SW:    return {OP_SW, rs, rt, imm};
            K_BEQ:   return {OP_BEQ, rs, rt, imm};
            K_BNE:   return {OP_BNE, rs, rt, imm};
            K_BGEZ:  return {OP_REGIMM, rs, RT_BGEZ, imm};
            K_BLTZ:  return {OP_REGIMM, rs, RT_BLTZ, imm};
            K_BGTZ:  return {OP_BGTZ, rs, 5'd0, imm};
            K_BLEZ:  return {OP_BLEZ, rs, 5'd0, imm};
            K_J:     return {OP_J, 26'(rnd(26))};
            K_JAL:   return {OP_JAL, 26'(rnd(26))};
            K_JR:    return {OP_SPECIAL, rs, 15'd0, FUNC_JR};
            default: return {6'h3f, 26'(rnd(26))};
        endcase
    endfunction

    function automatic int alu_index(int kind);
        case (kind)
            K_ADDU, K_ADDIU, K_LW, K_SW, K_JAL: return ALU_ADD;
            K_SUBU: return ALU_SUB;
            K_SLT:  return ALU_SLT;
            K_SLTU: return ALU_SLTU;
            K_AND:  return ALU_AND;
            K_NOR:  return ALU_NOR;
            K_OR:   return ALU_OR;
            K_XOR:  return ALU_XOR;
            K_SLL:  return ALU_SLL;
            K_SRL:  return ALU_SRL;
            K_SRA:  return ALU_SRA;
            K_LUI:  return ALU_LUI;
            default: return -1;
        endcase
    endfunction

    function automatic ctrl_t ctrl_ref(int kind, logic [31:0] inst);
        ctrl_t c;
        c = '0;
        if (alu_index(kind) >= 0) c.alu_op[alu_index(kind)] = 1'b1;
        if (kind <= K_SRA) begin
            c.gr_we = 1'b1;
            c.dest  = inst[15:11];
        end
        c.src1_is_sa = (kind == K_SLL) || (kind == K_SRL) || (kind == K_SRA);
        if (kind == K_ADDIU || kind == K_LUI || kind == K_LW) begin
            c.gr_we = 1'b1;
            c.dest  = inst[20:16];
        end
        c.src2_is_imm = (kind >= K_ADDIU) && (kind <= K_SW);
        c.mem_read    = (kind == K_LW);
        c.mem_we      = (kind == K_SW);
        if (kind == K_JAL) begin
            c.src1_is_pc = 1'b1;
            c.src2_is_8  = 1'b1;
            c.gr_we      = 1'b1;
            c.dest       = LINK_REG;
        end
        c.reserved_inst = (kind == K_RSV);
        return c;
    endfunction

    // execute, then memory, then write-back, then the register model
    function automatic logic [31:0] operand(logic [4:0] a);
        if (a == 5'd0) return '0;
        if (es_fwd.valid && es_fwd.we && es_fwd.waddr == a) return es_fwd.data;
        if (ms_fwd.valid && ms_fwd.we && ms_fwd.waddr == a) return ms_fwd.data;
        if (wb_bus.we && wb_bus.waddr == a) return wb_bus.wdata;
        return reg_model[a];
    endfunction

    function automatic logic load_hazard(logic [4:0] a);
        return a != 5'd0 && es_fwd.valid && es_fwd.we && es_fwd.waddr == a && es_fwd.is_load;
    endfunction

    function automatic logic taken_ref(int kind, logic [31:0] rsv, logic [31:0] rtv);
        case (kind)
            K_BEQ:  return rsv == rtv;
            K_BNE:  return rsv != rtv;
            K_BGEZ: return !rsv[31];
            K_BLTZ: return rsv[31];
            K_BLEZ: return rsv[31] || rsv == '0;
            K_BGTZ: return !(rsv[31] || rsv == '0);
            K_J, K_JAL, K_JR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] target_ref(int kind, logic [31:0] pc, logic [31:0] inst,
                                               logic [31:0] rsv);
        logic [31:0] pc4;
        pc4 = pc + 32'd4;
        if (kind == K_JR) return rsv;
        if (kind == K_J || kind == K_JAL) return {pc4[31:28], inst[25:0], 2'b00};
        return pc4 + {{14{inst[15]}}, inst[15:0], 2'b00};
    endfunction

    task automatic check_val(string name, logic [63:0] exp, logic [63:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, got);
        end
    endtask

    task automatic check_cycle();
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] rsv;
        logic [31:0] rtv;
        int          kind;
        logic        stall;
        if (q_pc.size() == 0) begin
            check_val("empty ds_allowin", 64'(1'b1), 64'(ds_allowin));
            check_val("empty ds_to_es_valid", 64'(1'b0), 64'(ds_to_es_valid));
            check_val("empty br taken", 64'(1'b0), 64'(br_bus.taken));
        end else begin
            pc    = q_pc[0];
            inst  = q_inst[0];
            kind  = q_kind[0];
            rsv   = operand(inst[25:21]);
            rtv   = operand(inst[20:16]);
            stall = load_hazard(inst[25:21]) || load_hazard(inst[20:16]);
            check_val("ds_to_es_valid", 64'(!stall), 64'(ds_to_es_valid));
            check_val("ds_allowin", 64'(!stall && es_allowin), 64'(ds_allowin));
            check_val("br taken", 64'(!stall && taken_ref(kind, rsv, rtv)), 64'(br_bus.taken));
            if (!stall) begin
                check_val("ctrl", 64'(ctrl_ref(kind, inst)), 64'(ds_to_es_bus.ctrl));
                check_val("imm", 64'(inst[15:0]), 64'(ds_to_es_bus.imm));
                check_val("rs_value", 64'(rsv), 64'(ds_to_es_bus.rs_value));
                check_val("rt_value", 64'(rtv), 64'(ds_to_es_bus.rt_value));
                check_val("pc", 64'(pc), 64'(ds_to_es_bus.pc));
                if (kind >= K_BEQ && kind <= K_JR) begin
                    check_val("br target", 64'(target_ref(kind, pc, inst, rsv)),
                              64'(br_bus.target));
                end
                if (es_allowin) begin
                    check_val("pc order", 64'(last_pc + 32'd4), 64'(ds_to_es_bus.pc));
                    last_pc = pc;
                    xfers++;
                    void'(q_pc.pop_front());
                    void'(q_inst.pop_front());
                    void'(q_kind.pop_front());
                end
            end
        end
        if (fs_valid && ds_allowin) begin
            q_pc.push_back(fs_bus.pc);
            q_inst.push_back(fs_bus.inst);
            q_kind.push_back(cur_kind);
        end
        if (wb_bus.we && wb_bus.waddr != 5'd0) reg_model[wb_bus.waddr] = wb_bus.wdata;
    endtask

    // outputs settle between the rising edges
    always @(negedge clk) begin
        if (!reset) check_cycle();
    end

    function automatic fwd_src_t random_src();
        fwd_src_t s;
        s.valid   = rnd(1) != 0;
        s.we      = rnd(1) != 0;
        s.waddr   = 5'(rnd(3));
        s.data    = rnd(32);
        s.is_load = rnd(2) == 0;
        return s;
    endfunction

    task automatic load_next();
        cur_kind = int'(rnd(5)) % 25;
        fs_bus  <= '{pc: next_pc, inst: make_inst(cur_kind)};
        next_pc  = next_pc + 32'd4;
    endtask

    initial begin
        reset      = 1'b1;
        fs_valid   = 1'b0;
        fs_bus     = '0;
        es_allowin = 1'b0;
        es_fwd     = '0;
        ms_fwd     = '0;
        wb_bus     = '0;
        next_pc    = 32'h0000_1000;
        last_pc    = 32'h0000_0ffc;
        cur_kind   = K_RSV;
        xfers      = 0;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        for (int i = 0; i < NUM_REGS; i++) reg_model[i] = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        // every register gets a known value first
        for (int i = 0; i < NUM_REGS; i++) begin
            @(posedge clk);
            wb_bus <= '{we: 1'b1, waddr: 5'(i), wdata: 32'(i) * 32'h9e37_79b1 + 32'h5a5a};
        end
        @(posedge clk);
        wb_bus <= '0;
        load_next();
        cycles = 0;
        while (xfers < NUM_XFERS && cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
            if (fs_valid && ds_allowin) load_next();
            fs_valid   <= rnd(2) != 0;
            es_allowin <= rnd(2) != 0;
            // forwarding inputs held on about half the cycles
            if (rnd(1) != 0) begin
                es_fwd <= random_src();
                ms_fwd <= random_src();
                wb_bus <= '{we: rnd(1) != 0, waddr: 5'(rnd(3)), wdata: rnd(32)};
            end
        end
        if (xfers < NUM_XFERS) begin
            timeouts++;
            $display("timeout: only %0d instructions reached execute", xfers);
        end
        $display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/id_pkg.sv
verilog/regfile.sv
verilog/operand_bypass.sv
verilog/id_decoder.sv
verilog/branch_unit.sv
verilog/id_pipe_reg.sv
verilog/id_stage.sv
testbench/id_stage_props.sv
testbench/tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_id_stage -o sim_id_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_id_stage > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi

exit 0
